//--- dv/l2c_cmp_vectors.txt
# Compare stage requests, one per line
# Stimulus: name op addr hit_way hit_status vict_way vict_valid vict_tag data_vld
#   data_busy tag_busy snoop_delay second_push
# Expected: create resp(hit,shared,dirty) data_req_count data_wen data_index tag_wen
#   status_wen(fifo,v,s,d,p) status_din fifo_din snoop_cycles snoop_addr stall_seen
# Opcodes in hex as in the package, hit_way -1 is a miss, busy and delay in cycles
wud_miss_refill 7 0abcde1a5 -1 0 5 1 123456 1 0 0 0 0 1 0 1 1 0ba5 0020 0f a 0040 0 0 0
read_hit 1 1000000c3 9 8 2 1 00aa55 0 0 0 0 0 0 4 1 0 12c3 0000 00 0 0000 0 0 0
read_miss 1 00f0f0077 -1 0 3 1 0c0ffe 0 0 0 0 0 1 0 0 0 0000 0000 00 0 0000 0 0 0
cln_dirty_hit 3 013579bdf 12 a 0 1 000111 0 2 0 0 0 0 5 1 0 19df 0000 02 8 0002 0 0 1
cln_clean_hit 3 000000155 4 8 1 0 000000 0 0 0 0 0 1 4 0 0 0000 0000 00 0 0000 0 0 0
alct_vict_vld 2 1fedcb0a9 -1 0 5 1 abcdef 0 0 4 3 0 1 4 0 0 0000 0000 11 9 0040 4 1579bdea9 1
alct_vict_inv 2 000000042 -1 0 7 0 000000 0 0 0 0 0 1 6 0 0 0000 0000 11 1 0100 0 0 0
data_busy_write 5 00000a1f3 3 8 6 1 000000 1 3 0 0 1 1 4 1 1 07f3 0000 06 e 0080 0 0 1
inv_hit 9 0000001ff 1 e 4 1 000000 0 0 0 0 0 1 7 0 0 0000 0000 0e 0 0020 0 0 0

//--- src.f
hdl/l2c_cmp_pkg.sv
hdl/l2c_cmp_stage.sv
hdl/l2c_cmp_way_sel.sv
hdl/l2c_cmp_status_updt.sv
hdl/l2c_cmp_data_req.sv
hdl/l2c_cmp_snoop_req.sv
hdl/l2c_cmp_rfifo_resp.sv
hdl/l2c_cmp_top.sv
dv/l2c_cmp_tb.sv

//--- dv/l2c_cmp_tb.sv
// Self-checking testbench for the L2 cache compare stage, driven from a vector file
`timescale 1ns/1ps

module l2c_cmp_tb
  import l2c_cmp_pkg::*;
();

  localparam int NUM_WAYS   = 16;
  localparam int MAX_CYCLES = 20;

  logic                    l2c_clk;
  logic                    cpurst_b;
  logic                    in_vld;
  stage_req_t              in_req;
  logic [NUM_WAYS-1:0]     way_hit;
  way_rd_t [NUM_WAYS-1:0]  way_rd;
  logic [NUM_WAYS-1:0]     way_fifo;
  logic [NUM_WAYS-1:0]     refill_ptr;
  logic                    data_vld;
  logic                    data_ram_idle;
  logic                    tag_ram_idle;
  logic                    snoop_ready;
  logic                    stage_vld;
  logic                    stage_stall;
  tag_wr_t                 tag_wr;
  status_wr_t              status_wr;
  data_req_t               data_req;
  snoop_req_t              snoop;
  rfifo_t                  rfifo;

  logic [31:0]             lcg_state;
  int                      n_tests;
  int                      n_errors;

  // Stimulus fields of the current vector
  string                   test_name;
  int                      op_code;
  logic [ADDR_W-1:0]       addr;
  int                      hit_way;
  logic [3:0]              hit_st;
  int                      vict_way;
  int                      vict_vld;
  logic [TAG_W-1:0]        vict_tag;
  int                      dvld;
  int                      dbusy;
  int                      tbusy;
  int                      snoop_dly;
  int                      dup;

  // Expected fields of the current vector
  int                      exp_create;
  logic [2:0]              exp_resp;
  int                      exp_dreq;
  int                      exp_dwen;
  logic [DATA_INDEX_W-1:0] exp_didx;
  logic [15:0]             exp_tag_wen;
  logic [4:0]              exp_st_wen;
  logic [3:0]              exp_st_din;
  logic [15:0]             exp_fifo_din;
  int                      exp_snoop;
  logic [ADDR_W-1:0]       exp_snoop_addr;
  int                      exp_stall;

  // What the DUT showed during the current request
  int                      obs_create;
  logic [2:0]              obs_resp;
  int                      obs_dreq;
  int                      obs_dwen;
  logic [DATA_INDEX_W-1:0] obs_didx;
  logic [15:0]             obs_tag_wen;
  logic [4:0]              obs_st_wen;
  logic [3:0]              obs_st_din;
  logic [15:0]             obs_fifo_din;
  int                      obs_snoop;
  logic [ADDR_W-1:0]       obs_snoop_addr;
  int                      obs_stall;

  l2c_cmp_top #(.NUM_WAYS(NUM_WAYS)) u_dut (
    .l2c_clk       (l2c_clk),
    .cpurst_b      (cpurst_b),
    .in_vld        (in_vld),
    .in_req        (in_req),
    .way_hit       (way_hit),
    .way_rd        (way_rd),
    .way_fifo      (way_fifo),
    .refill_ptr    (refill_ptr),
    .data_vld      (data_vld),
    .data_ram_idle (data_ram_idle),
    .tag_ram_idle  (tag_ram_idle),
    .snoop_ready   (snoop_ready),
    .stage_vld     (stage_vld),
    .stage_stall   (stage_stall),
    .tag_wr        (tag_wr),
    .status_wr     (status_wr),
    .data_req      (data_req),
    .snoop         (snoop),
    .rfifo         (rfifo)
  );

  always #5 l2c_clk = ~l2c_clk;

  //==========================================================================
  // Helpers
  //==========================================================================
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Refill, release and alct write the victim way, the rest the hit way
  function automatic logic [MAX_WAYS-1:0] expected_status_way();
    cmp_op_e op;
    logic    is_write;

    op       = cmp_op_e'(op_code);
    is_write = (op == OP_WRITE_SD) || (op == OP_WRITE_SC)
            || (op == OP_WRITE_UD) || (op == OP_WRITE_UC);
    if ((is_write && hit_way < 0) || op == OP_RELEASE || op == OP_ALCT)
      return way_fifo;
    else
      return way_hit;
  endfunction

  task automatic compare_field(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
    assert (expected === actual)
    else
    begin
      $display("MISMATCH %s %s expected %0h actual %0h", test_name, field, expected, actual);
      n_errors++;
    end
  endtask

  task automatic check_reset_state();
    assert (!stage_vld && !tag_wr.cen && !status_wr.cen && !data_req.req
            && !snoop.vld && !rfifo.create)
    else
    begin
      $display("ERROR: outputs were not idle after reset");
      n_errors++;
    end
  endtask

  // Filler ways first, then the hit way and the victim way from the vector
  task automatic build_ways();
    for (int i = 0; i < NUM_WAYS; i++)
    begin
      lcg_state        = lcg_next(lcg_state);
      way_rd[i].tag    = lcg_state[31:8];
      way_rd[i].status = line_status_t'(lcg_state[3:0]);
    end
    way_hit = '0;
    if (hit_way >= 0)
    begin
      way_hit[hit_way]        = 1'b1;
      way_rd[hit_way].status  = line_status_t'(hit_st);
    end
    way_fifo                 = '0;
    way_fifo[vict_way]       = 1'b1;
    refill_ptr               = way_fifo;
    way_rd[vict_way].tag     = vict_tag;
    way_rd[vict_way].status  = line_status_t'({vict_vld != 0, 3'b000});
  endtask

  task automatic clear_observed();
    obs_create     = 0;
    obs_resp       = '0;
    obs_dreq       = 0;
    obs_dwen       = 0;
    obs_didx       = '0;
    obs_tag_wen    = '0;
    obs_st_wen     = '0;
    obs_st_din     = '0;
    obs_fifo_din   = '0;
    obs_snoop      = 0;
    obs_snoop_addr = '0;
    obs_stall      = 0;
  endtask

  task automatic sample_cycle(input int cyc, input int sid);
    if (cyc == 0)
    begin
      assert (stage_vld)
      else
      begin
        $display("ERROR %s: the stage did not take the request", test_name);
        n_errors++;
      end
    end
    if (stage_vld)
    begin
      // Held request keeps its own id
      compare_field("sid", sid, rfifo.sid);
      obs_resp = rfifo.resp;
      if (stage_stall)
        obs_stall = 1;
      if (data_req.req && data_ram_idle)
      begin
        obs_dreq++;
        obs_dwen = data_req.wen;
        obs_didx = data_req.index;
      end
      if (tag_wr.cen)
      begin
        obs_tag_wen = tag_wr.wen;
        compare_field("tag_index", addr[TAG_INDEX_W-1:0], tag_wr.index);
      end
      if (status_wr.cen)
      begin
        obs_st_wen   = status_wr.wen;
        obs_st_din   = status_wr.din;
        obs_fifo_din = status_wr.fifo_din;
        compare_field("status_way", expected_status_way(), status_wr.way);
      end
      if (snoop.vld)
      begin
        obs_snoop++;
        obs_snoop_addr = snoop.addr;
        compare_field("snoop_sid", sid, snoop.sid);
      end
      if (rfifo.create)
        obs_create = 1;
    end
  endtask

  task automatic check_results();
    compare_field("create", exp_create, obs_create);
    compare_field("resp", exp_resp, obs_resp);
    compare_field("data_req_count", exp_dreq, obs_dreq);
    compare_field("data_wen", exp_dwen, obs_dwen);
    compare_field("data_index", exp_didx, obs_didx);
    compare_field("tag_wen", exp_tag_wen, obs_tag_wen);
    compare_field("status_wen", exp_st_wen, obs_st_wen);
    compare_field("status_din", exp_st_din, obs_st_din);
    compare_field("fifo_din", exp_fifo_din, obs_fifo_din);
    compare_field("snoop_cycles", exp_snoop, obs_snoop);
    compare_field("snoop_addr", exp_snoop_addr, obs_snoop_addr);
    compare_field("stall", exp_stall, obs_stall);
  endtask

  //==========================================================================
  // One request from accept to response
  //==========================================================================
  task automatic run_vector(output logic timed_out);
    int   sid;
    int   cyc;
    int   err_start;
    logic finished;

    sid       = (n_tests + 1) % 32;
    err_start = n_errors;
    timed_out = 1'b0;
    clear_observed();
    @(posedge l2c_clk);
    #1;
    build_ways();
    in_req.addr   = addr;
    in_req.sid    = SID_W'(sid);
    in_req.op     = cmp_op_e'(op_code);
    data_vld      = (dvld != 0);
    data_ram_idle = (dbusy == 0);
    tag_ram_idle  = (tbusy == 0);
    snoop_ready   = 1'b0;
    in_vld        = 1'b1;
    @(posedge l2c_clk);
    cyc      = 0;
    finished = 1'b0;
    while (!finished && !timed_out)
    begin
      #1;
      // Optional second push right behind the first one
      in_vld        = (cyc == 0) && (dup != 0);
      in_req.sid    = SID_W'(sid + 1);
      data_ram_idle = (cyc >= dbusy);
      tag_ram_idle  = (cyc >= tbusy);
      snoop_ready   = (snoop_dly != 0) && (cyc == snoop_dly);
      #4;
      sample_cycle(cyc, sid);
      if (rfifo.create || !stage_vld)
        finished = 1'b1;
      else if (cyc == MAX_CYCLES - 1)
      begin
        $display("ERROR %s: no response within %0d cycles, the stage stayed busy",
                 test_name, MAX_CYCLES);
        n_errors++;
        timed_out = 1'b1;
      end
      else
      begin
        @(posedge l2c_clk);
        cyc++;
      end
    end
    if (!timed_out)
      check_results();
    n_tests++;
    $display("test %s %s", test_name, (n_errors == err_start) ? "passed" : "FAILED");
  endtask

  //==========================================================================
  // Main sequence
  //==========================================================================
  initial
  begin
    int    fd;
    int    nfields;
    string line;
    logic  abort;

    l2c_clk       = 1'b0;
    cpurst_b      = 1'b0;
    in_vld        = 1'b0;
    in_req        = '0;
    way_hit       = '0;
    way_rd        = '0;
    way_fifo      = '0;
    refill_ptr    = '0;
    data_vld      = 1'b0;
    data_ram_idle = 1'b1;
    tag_ram_idle  = 1'b1;
    snoop_ready   = 1'b0;
    lcg_state     = 32'h17b6_34db;
    n_tests       = 0;
    n_errors      = 0;
    abort         = 1'b0;

    repeat (2) @(posedge l2c_clk);
    #1;
    cpurst_b = 1'b1;
    #4;
    check_reset_state();

    fd = $fopen("dv/l2c_cmp_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open the vector file");
      n_errors++;
    end
    else
    begin
      while (!abort && $fgets(line, fd) != 0)
      begin
        if (line.len() < 2 || line.substr(0, 0) == "#")
          continue;
        nfields = $sscanf(line,
          "%s %h %h %d %h %d %d %h %d %d %d %d %d %d %h %d %d %h %h %h %h %h %d %h %d",
          test_name, op_code, addr, hit_way, hit_st, vict_way, vict_vld, vict_tag,
          dvld, dbusy, tbusy, snoop_dly, dup, exp_create, exp_resp, exp_dreq,
          exp_dwen, exp_didx, exp_tag_wen, exp_st_wen, exp_st_din, exp_fifo_din,
          exp_snoop, exp_snoop_addr, exp_stall);
        if (nfields != 25)
        begin
          $display("ERROR: vector line has the wrong number of fields: %s", line);
          n_errors++;
        end
        else
          run_vector(abort);
      end
      $fclose(fd);
    end

    $display("Tests run %0d, errors %0d", n_tests, n_errors);
    if (n_errors == 0 && n_tests > 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- hdl/l2c_cmp_top.sv
// L2 cache compare stage top level connecting the stage submodules
`timescale 1ns/1ps

module l2c_cmp_top
  import l2c_cmp_pkg::*;
#(
  parameter int NUM_WAYS = 16
)
(
  input  logic                   l2c_clk,
  input  logic                   cpurst_b,
  input  logic                   in_vld,
  input  stage_req_t             in_req,
  input  logic [NUM_WAYS-1:0]    way_hit,
  input  way_rd_t [NUM_WAYS-1:0] way_rd,
  input  logic [NUM_WAYS-1:0]    way_fifo,
  input  logic [NUM_WAYS-1:0]    refill_ptr,
  input  logic                   data_vld,
  input  logic                   data_ram_idle,
  input  logic                   tag_ram_idle,
  input  logic                   snoop_ready,
  output logic                   stage_vld,
  output logic                   stage_stall,
  output tag_wr_t                tag_wr,
  output status_wr_t             status_wr,
  output data_req_t              data_req,
  output snoop_req_t             snoop,
  output rfifo_t                 rfifo
);

  stage_req_t       cur;
  logic             load;
  logic             hit;
  line_status_t     hit_status;
  logic [TAG_W-1:0] victim_tag;
  logic             victim_vld;
  logic             req_vld;
  logic             pend_set;
  logic             refill;
  logic             stall_by_data;
  logic             snoop_grant;

  l2c_cmp_stage u_stage (
    .l2c_clk       (l2c_clk),
    .cpurst_b      (cpurst_b),
    .in_vld        (in_vld),
    .in_req        (in_req),
    .stall_by_data (stall_by_data),
    .req_vld       (req_vld),
    .tag_ram_idle  (tag_ram_idle),
    .cur           (cur),
    .stage_vld     (stage_vld),
    .stage_stall   (stage_stall),
    .load          (load)
  );

  l2c_cmp_way_sel #(.NUM_WAYS(NUM_WAYS)) u_way_sel (
    .stage_vld  (stage_vld),
    .way_hit    (way_hit),
    .way_rd     (way_rd),
    .way_fifo   (way_fifo),
    .hit        (hit),
    .hit_status (hit_status),
    .victim_tag (victim_tag),
    .victim_vld (victim_vld)
  );

  l2c_cmp_status_updt #(.NUM_WAYS(NUM_WAYS)) u_status_updt (
    .stage_vld     (stage_vld),
    .cur           (cur),
    .hit           (hit),
    .hit_status    (hit_status),
    .victim_vld    (victim_vld),
    .snoop_grant   (snoop_grant),
    .stall_by_data (stall_by_data),
    .way_hit       (way_hit),
    .way_rd        (way_rd),
    .way_fifo      (way_fifo),
    .refill_ptr    (refill_ptr),
    .tag_wr        (tag_wr),
    .status_wr     (status_wr),
    .req_vld       (req_vld),
    .pend_set      (pend_set),
    .refill        (refill)
  );

  l2c_cmp_data_req #(.NUM_WAYS(NUM_WAYS)) u_data_req (
    .l2c_clk       (l2c_clk),
    .cpurst_b      (cpurst_b),
    .load          (load),
    .stage_vld     (stage_vld),
    .cur           (cur),
    .hit           (hit),
    .hit_status    (hit_status),
    .refill        (refill),
    .way_hit       (way_hit),
    .refill_ptr    (refill_ptr),
    .data_vld      (data_vld),
    .data_ram_idle (data_ram_idle),
    .data_req      (data_req),
    .stall_by_data (stall_by_data)
  );

  l2c_cmp_snoop_req u_snoop_req (
    .l2c_clk     (l2c_clk),
    .cpurst_b    (cpurst_b),
    .load        (load),
    .stage_vld   (stage_vld),
    .cur         (cur),
    .victim_tag  (victim_tag),
    .victim_vld  (victim_vld),
    .snoop_ready (snoop_ready),
    .snoop       (snoop),
    .snoop_grant (snoop_grant)
  );

  l2c_cmp_rfifo_resp u_rfifo_resp (
    .stage_vld    (stage_vld),
    .stage_stall  (stage_stall),
    .cur          (cur),
    .hit          (hit),
    .hit_status   (hit_status),
    .pend_set     (pend_set),
    .victim_vld   (victim_vld),
    .data_vld     (data_vld),
    .tag_ram_idle (tag_ram_idle),
    .rfifo        (rfifo)
  );

endmodule

//--- hdl/l2c_cmp_rfifo_resp.sv
// Response FIFO entry create decision and response bits
`timescale 1ns/1ps

module l2c_cmp_rfifo_resp
  import l2c_cmp_pkg::*;
(
  input  logic         stage_vld,
  input  logic         stage_stall,
  input  stage_req_t   cur,
  input  logic         hit,
  input  line_status_t hit_status,
  input  logic         pend_set,
  input  logic         victim_vld,
  input  logic         data_vld,
  input  logic         tag_ram_idle,
  output rfifo_t       rfifo
);

  logic hit_unique;
  logic create_op;

  assign hit_unique = hit & ~hit_status.shared;

  // Per-opcode completion condition
  always_comb
  begin
    case (cur.op)
      OP_READ:        create_op = ~hit;
      OP_WRITE_SD,
      OP_WRITE_SC,
      OP_WRITE_UD,
      OP_WRITE_UC:    create_op = data_vld & tag_ram_idle;
      OP_ALCT,
      OP_RELEASE:     create_op = tag_ram_idle;
      OP_CLN:         create_op = ~hit | ~hit_status.dirty;
      OP_ICLN:        create_op = ~hit | (~hit_status.dirty & tag_ram_idle);
      OP_INV:         create_op = ~hit | tag_ram_idle;
      OP_MAKE_UNIQUE: create_op = ~hit_status.shared | tag_ram_idle;
      OP_MAKE_SHARED: create_op = ~hit_unique | tag_ram_idle;
      default:        create_op = 1'b0;
    endcase
  end

  always_comb
  begin
    rfifo.create      = stage_vld & ~stage_stall & create_op;
    rfifo.sid         = cur.sid;
    // hit also flags a finished alct
    rfifo.resp.hit    = hit | pend_set;
    // an alct into an invalid way needed no snoop
    rfifo.resp.shared = hit_status.shared | ((cur.op == OP_ALCT) & ~victim_vld);
    rfifo.resp.dirty  = hit_status.dirty;
  end

endmodule

//--- hdl/l2c_cmp_snoop_req.sv
// Victim snoop request for allocates, with snoop grant latch
`timescale 1ns/1ps

module l2c_cmp_snoop_req
  import l2c_cmp_pkg::*;
(
  input  logic             l2c_clk,
  input  logic             cpurst_b,
  input  logic             load,
  input  logic             stage_vld,
  input  stage_req_t       cur,
  input  logic [TAG_W-1:0] victim_tag,
  input  logic             victim_vld,
  input  logic             snoop_ready,
  output snoop_req_t       snoop,
  output logic             snoop_grant
);

  logic granted;

  // Ready may be a single pulse, so keep it until the next request
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      granted <= 1'b0;
    end
    else if (load)
    begin
      granted <= 1'b0;
    end
    else if (snoop_ready)
    begin
      granted <= 1'b1;
    end
  end

  assign snoop_grant = snoop_ready | granted;

  // Evict a valid victim before the allocate
  always_comb
  begin
    snoop.vld  = stage_vld & (cur.op == OP_ALCT) & victim_vld & ~granted;
    snoop.addr = {victim_tag, cur.addr[TAG_INDEX_W-1:0]};
    snoop.sid  = cur.sid;
  end

endmodule

//--- hdl/l2c_cmp_data_req.sv
// Data RAM request with one-shot tracking, data stall and way-encoded index
`timescale 1ns/1ps

module l2c_cmp_data_req
  import l2c_cmp_pkg::*;
#(
  parameter int NUM_WAYS = 16
)
(
  input  logic                l2c_clk,
  input  logic                cpurst_b,
  input  logic                load,
  input  logic                stage_vld,
  input  stage_req_t          cur,
  input  logic                hit,
  input  line_status_t        hit_status,
  input  logic                refill,
  input  logic [NUM_WAYS-1:0] way_hit,
  input  logic [NUM_WAYS-1:0] refill_ptr,
  input  logic                data_vld,
  input  logic                data_ram_idle,
  output data_req_t           data_req,
  output logic                stall_by_data
);

  localparam int WAY_ID_W = $clog2(NUM_WAYS);
  localparam int LOW_W    = DATA_INDEX_W - WAY_ID_W;

  logic                op_write;
  logic                data_rd;
  logic                data_wr;
  logic                done;
  logic [NUM_WAYS-1:0] way_ptr;
  logic [WAY_ID_W-1:0] way_id;

  assign op_write = (cur.op == OP_WRITE_SD) | (cur.op == OP_WRITE_SC)
                  | (cur.op == OP_WRITE_UD) | (cur.op == OP_WRITE_UC);

  // Read hits and dirty cleans both pull the line out of the data RAM
  assign data_rd = ((cur.op == OP_READ) & hit)
                 | (((cur.op == OP_CLN) | (cur.op == OP_ICLN)) & hit_status.dirty);
  assign data_wr = op_write & data_vld;

  // Set once the data RAM took the request
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      done <= 1'b0;
    end
    else if (load)
    begin
      done <= 1'b0;
    end
    else if (data_req.req && data_ram_idle)
    begin
      done <= 1'b1;
    end
  end

  //==========================================================================
  // Way encode and request
  //==========================================================================
  assign way_ptr = refill ? refill_ptr : way_hit;

  always_comb
  begin
    way_id = '0;
    for (int i = 0; i < NUM_WAYS; i++)
    begin
      if (way_ptr[i])
        way_id = way_id | WAY_ID_W'(i);
    end
  end

  always_comb
  begin
    data_req.req   = stage_vld & (data_rd | data_wr) & ~done;
    data_req.wen   = data_wr;
    data_req.index = {way_id, cur.addr[LOW_W-1:0]};
  end

  // Writes also wait for their data to show up
  assign stall_by_data = stage_vld & ~done
                       & ((data_rd & ~data_ram_idle)
                       | (op_write & (~data_vld | ~data_ram_idle)));

  // Way encoder needs a single way behind every request
  a_way_onehot: assert property (
    @(posedge l2c_clk) disable iff (!cpurst_b)
    data_req.req |-> $onehot(way_ptr)
  );

endmodule

//--- hdl/l2c_cmp_status_updt.sv
// Line status update with the tag RAM and status RAM write requests
`timescale 1ns/1ps

module l2c_cmp_status_updt
  import l2c_cmp_pkg::*;
#(
  parameter int NUM_WAYS = 16
)
(
  input  logic                   stage_vld,
  input  stage_req_t             cur,
  input  logic                   hit,
  input  line_status_t           hit_status,
  input  logic                   victim_vld,
  input  logic                   snoop_grant,
  input  logic                   stall_by_data,
  input  logic [NUM_WAYS-1:0]    way_hit,
  input  way_rd_t [NUM_WAYS-1:0] way_rd,
  input  logic [NUM_WAYS-1:0]    way_fifo,
  input  logic [NUM_WAYS-1:0]    refill_ptr,
  output tag_wr_t                tag_wr,
  output status_wr_t             status_wr,
  output logic                   req_vld,
  output logic                   pend_set,
  output logic                   refill
);

  logic                op_write;
  logic                op_write_dirty;
  logic                op_write_clean;
  logic                op_write_shared;
  logic                op_write_unique;
  logic                hit_unique;
  logic                valid_clr;
  logic                updt;
  line_status_t        set_bits;
  line_status_t        clr_bits;
  line_status_t        old_status;
  logic [NUM_WAYS-1:0] way_ptr;
  logic [NUM_WAYS-1:0] fifo_rot;

  //==========================================================================
  // Opcode decode
  //==========================================================================
  assign op_write_dirty  = (cur.op == OP_WRITE_SD) | (cur.op == OP_WRITE_UD);
  assign op_write_clean  = (cur.op == OP_WRITE_SC) | (cur.op == OP_WRITE_UC);
  assign op_write_shared = (cur.op == OP_WRITE_SD) | (cur.op == OP_WRITE_SC);
  assign op_write_unique = (cur.op == OP_WRITE_UD) | (cur.op == OP_WRITE_UC);
  assign op_write        = op_write_dirty | op_write_clean;
  assign hit_unique      = hit & ~hit_status.shared;

  // Write miss allocates the refill way
  assign refill    = op_write & ~hit;
  assign valid_clr = ((cur.op == OP_INV) | (cur.op == OP_ICLN)) & hit;
  // Alct may only pend once the victim is gone or snooped out
  assign pend_set  = (cur.op == OP_ALCT) & (~victim_vld | snoop_grant);

  //==========================================================================
  // Set and clear patterns
  //==========================================================================
  always_comb
  begin
    set_bits.valid  = refill;
    set_bits.shared = op_write_shared | ((cur.op == OP_MAKE_SHARED) & hit_unique);
    set_bits.dirty  = op_write_dirty;
    set_bits.pend   = pend_set;

    clr_bits.valid  = valid_clr;
    clr_bits.shared = op_write_unique | valid_clr
                    | ((cur.op == OP_MAKE_UNIQUE) & hit_status.shared);
    clr_bits.dirty  = op_write_clean | valid_clr
                    | (((cur.op == OP_CLN) | (cur.op == OP_ICLN)) & hit_status.dirty);
    clr_bits.pend   = (cur.op == OP_RELEASE) | refill;
  end

  assign updt    = |(set_bits | clr_bits);
  // Alct holds the tag RAM even while it waits for the snoop grant
  assign req_vld = stage_vld & (updt | (cur.op == OP_ALCT));

  // Target way of the status write
  always_comb
  begin
    if (refill || (cur.op == OP_RELEASE))
      way_ptr = refill_ptr;
    else if (cur.op == OP_ALCT)
      way_ptr = way_fifo;
    else
      way_ptr = way_hit;
  end

  always_comb
  begin
    old_status = '0;
    for (int i = 0; i < NUM_WAYS; i++)
    begin
      old_status = line_status_t'(old_status | (way_rd[i].status & {4{way_ptr[i]}}));
    end
  end

  // Replacement pointer advances by one way on every pend set
  assign fifo_rot = {way_fifo[NUM_WAYS-2:0], way_fifo[NUM_WAYS-1]};

  //==========================================================================
  // RAM write requests
  //==========================================================================
  always_comb
  begin
    tag_wr.cen   = stage_vld & refill & ~stall_by_data;
    tag_wr.index = cur.addr[TAG_INDEX_W-1:0];
    tag_wr.wen   = MAX_WAYS'(refill_ptr & {NUM_WAYS{stage_vld & refill}});

    status_wr.cen      = stage_vld & updt & ~stall_by_data;
    status_wr.way      = MAX_WAYS'(way_ptr);
    status_wr.wen.fifo = pend_set;
    status_wr.wen.line = line_status_t'(set_bits | clr_bits);
    // Refilled line starts from scratch
    status_wr.din      = refill ? set_bits
                                : line_status_t'((old_status | set_bits) & ~clr_bits);
    status_wr.fifo_din = MAX_WAYS'(fifo_rot);
  end

endmodule

//--- hdl/l2c_cmp_way_sel.sv
// Hit summary with hit-way status and victim-way tag selection
`timescale 1ns/1ps

module l2c_cmp_way_sel
  import l2c_cmp_pkg::*;
#(
  parameter int NUM_WAYS = 16
)
(
  input  logic                   stage_vld,
  input  logic [NUM_WAYS-1:0]    way_hit,
  input  way_rd_t [NUM_WAYS-1:0] way_rd,
  input  logic [NUM_WAYS-1:0]    way_fifo,
  output logic                   hit,
  output line_status_t           hit_status,
  output logic [TAG_W-1:0]       victim_tag,
  output logic                   victim_vld
);

  assign hit = |way_hit;

  // AND-OR muxes, all-zero on a miss
  always_comb
  begin
    hit_status = '0;
    victim_tag = '0;
    victim_vld = 1'b0;
    for (int i = 0; i < NUM_WAYS; i++)
    begin
      hit_status = line_status_t'(hit_status | (way_rd[i].status & {4{way_hit[i]}}));
      victim_tag = victim_tag | (way_rd[i].tag & {TAG_W{way_fifo[i]}});
      victim_vld = victim_vld | (way_fifo[i] & way_rd[i].status.valid);
    end
  end

  // Tag compare never matches a line in two ways
  a_hit_onehot: assert final (!stage_vld || $onehot0(way_hit));

endmodule

//--- hdl/l2c_cmp_stage.sv
// Compare stage request register with stage valid and stall generation
`timescale 1ns/1ps

module l2c_cmp_stage
  import l2c_cmp_pkg::*;
(
  input  logic       l2c_clk,
  input  logic       cpurst_b,
  input  logic       in_vld,
  input  stage_req_t in_req,
  input  logic       stall_by_data,
  input  logic       req_vld,
  input  logic       tag_ram_idle,
  output stage_req_t cur,
  output logic       stage_vld,
  output logic       stage_stall,
  output logic       load
);

  // Both terms arrive already qualified by stage_vld
  assign stage_stall = stall_by_data | (req_vld & ~tag_ram_idle);
  assign load        = in_vld & ~stage_stall;

  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      stage_vld <= 1'b0;
    end
    else if (!stage_stall)
    begin
      stage_vld <= in_vld;
    end
  end

  // Request payload
  always_ff @(posedge l2c_clk)
  begin
    if (load)
    begin
      cur <= in_req;
    end
  end

  // A stalled request stays in place and stays valid
  a_hold_on_stall: assert property (
    @(posedge l2c_clk) disable iff (!cpurst_b)
    stage_stall |=> $stable(cur) && stage_vld
  );

endmodule

//--- hdl/l2c_cmp_pkg.sv
// L2 cache compare stage package with widths, opcodes and shared structs
package l2c_cmp_pkg;

  //==========================================================================
  // Widths
  //==========================================================================
  localparam int ADDR_W       = 33;
  localparam int TAG_INDEX_W  = 9;
  localparam int TAG_W        = ADDR_W - TAG_INDEX_W;
  localparam int DATA_INDEX_W = 13;
  localparam int SID_W        = 5;
  // Way vectors in the structs are sized for the largest cache
  localparam int MAX_WAYS     = 16;

  //==========================================================================
  // Request opcode
  //==========================================================================
  typedef enum logic [3:0] {
    OP_NOP         = 4'd0,
    OP_READ        = 4'd1,
    OP_ALCT        = 4'd2,
    OP_CLN         = 4'd3,
    OP_ICLN        = 4'd4,
    OP_WRITE_SD    = 4'd5,
    OP_WRITE_SC    = 4'd6,
    OP_WRITE_UD    = 4'd7,
    OP_WRITE_UC    = 4'd8,
    OP_INV         = 4'd9,
    OP_RELEASE     = 4'd10,
    OP_MAKE_UNIQUE = 4'd11,
    OP_MAKE_SHARED = 4'd12
  } cmp_op_e;

  //==========================================================================
  // Stage and RAM structs
  //==========================================================================
  typedef struct packed {
    logic valid;
    logic shared;
    logic dirty;
    logic pend;
  } line_status_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [SID_W-1:0]  sid;
    cmp_op_e           op;
  } stage_req_t;

  // One way as read back from tag and status RAMs
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    line_status_t     status;
  } way_rd_t;

  typedef struct packed {
    logic                   cen;
    logic [TAG_INDEX_W-1:0] index;
    logic [MAX_WAYS-1:0]    wen;
  } tag_wr_t;

  typedef struct packed {
    logic         fifo;
    line_status_t line;
  } status_wen_t;

  typedef struct packed {
    logic                cen;
    logic [MAX_WAYS-1:0] way;
    status_wen_t         wen;
    line_status_t        din;
    logic [MAX_WAYS-1:0] fifo_din;
  } status_wr_t;

  typedef struct packed {
    logic                    req;
    logic                    wen;
    logic [DATA_INDEX_W-1:0] index;
  } data_req_t;

  typedef struct packed {
    logic              vld;
    logic [ADDR_W-1:0] addr;
    logic [SID_W-1:0]  sid;
  } snoop_req_t;

  typedef struct packed {
    logic hit;
    logic shared;
    logic dirty;
  } rfifo_resp_t;

  typedef struct packed {
    logic             create;
    logic [SID_W-1:0] sid;
    rfifo_resp_t      resp;
  } rfifo_t;

endpackage
